// ==== hw/pdp1_pkg.sv ====
/*
 * Shared types and constants for the PDP-1 front end.
 * Imported by wildcard into each module header that needs them.
 */
package pdp1_pkg;

   // ================================================
   // Machine words
   // ================================================
   typedef logic [17:0] pdp_word_t;
   typedef logic [11:0] pdp_addr_t;

   // One tape line, bit 7 marks binary, bits 5..0 carry data
   typedef logic [7:0] tape_byte_t;

   // Read-in record, six tape lines, oldest line in the high bits
   typedef struct packed {
      logic [5:0] op;
      pdp_addr_t  addr;
      pdp_word_t  data;
   } rim_record_t;

   // Read-in opcodes (octal)
   typedef enum logic [5:0] {
      RIM_DIO = 6'o32,
      RIM_JMP = 6'o60
   } rim_op_e;

   // ================================================
   // FSM states
   // ================================================
   typedef enum logic {LOAD_IDLE, LOAD_RIM} loader_state_e;
   typedef enum logic {READ_IDLE, READ_COLLECT} reader_state_e;

   // Video line and frame position
   typedef logic [10:0] video_count_t;

   localparam int unsigned RIM_LINES = 6;
   localparam int unsigned BIN_LINES = 3;
   localparam pdp_addr_t RESET_START_ADDRESS = 12'o4;

endpackage

// ==== hw/tape_if.sv ====
/*
 * Tape byte stream from the download source, with the loader's hold-off.
 * Top level drives the stream, loader and reader sample it.
 */
`timescale 1ns/1ps

interface tape_if import pdp1_pkg::*; ();

   logic       download;   // High while a tape image streams
   logic       byte_wr;    // One-cycle byte strobe
   tape_byte_t byte_data;
   logic       hold;       // Source waits while high

   // Stream origin
   modport source (output download, output byte_wr, output byte_data, input hold);

   // RIM loader owns the hold-off
   modport loader (input download, input byte_wr, input byte_data, output hold);

   // Binary word reader only listens
   modport reader (input byte_wr, input byte_data);

endinterface

// ==== hw/rim_loader.sv ====
/*
 * Read-in-mode loader. Assembles six-line records from the tape stream,
 * turns dio records into memory writes and a jmp record into the start
 * address. Also keeps the hold-off toward the tape source and its timeout.
 */
`timescale 1ns/1ps

module rim_loader import pdp1_pkg::*; #(
   parameter int unsigned TIMEOUT_CYCLES = 50_000_000
) (
   input  logic      CLK_50M,
   input  logic      RESET,
   tape_if.loader    tape,
   input  logic      rim_enable,
   input  logic      rim_disable,
   output logic      rim_active,
   output logic      mem_we,
   output pdp_addr_t mem_addr,
   output pdp_word_t mem_data,
   output pdp_addr_t start_address
);

   // Timer saturates one past the limit
   localparam int unsigned TIMER_W = $clog2(TIMEOUT_CYCLES + 2);
   localparam logic [TIMER_W-1:0] TIMER_LIMIT = TIMER_W'(TIMEOUT_CYCLES);
   localparam logic [TIMER_W-1:0] TIMER_SAT = TIMER_W'(TIMEOUT_CYCLES + 1);

   localparam int unsigned LINE_W = $clog2(RIM_LINES);
   localparam logic [LINE_W-1:0] LAST_LINE = LINE_W'(RIM_LINES - 1);

   loader_state_e                state;
   logic [LINE_W-1:0]            line_cnt;
   logic [(RIM_LINES-1)*6-1:0]   line_sr;     // Five older data fields
   logic [TIMER_W-1:0]           timer_q;
   logic                         byte_valid;
   logic                         record_done;
   rim_record_t                  rec_next;
   rim_op_e                      rec_op;

   // Only binary lines count
   assign byte_valid = tape.byte_wr && tape.byte_data[7];

   // Record as it stands with the current line shifted in
   assign rec_next = {line_sr, tape.byte_data[5:0]};
   assign rec_op   = rim_op_e'(rec_next.op);

   // Sixth counted line in RIM mode, decoded on this edge
   assign record_done = (state == LOAD_RIM) && byte_valid
                        && (line_cnt == LAST_LINE) && !rim_disable;

   assign rim_active = (state == LOAD_RIM);

   // ================================================
   // Line shifter and decoded payload
   // ================================================
   always_ff @(posedge CLK_50M) begin
      if (byte_valid) begin
         line_sr <= rec_next[(RIM_LINES-1)*6-1:0];
      end
      if (record_done) begin
         mem_addr <= rec_next.addr;
         mem_data <= rec_next.data;
      end
   end

   // ================================================
   // Mode FSM and record decode
   // ================================================
   always_ff @(posedge CLK_50M) begin
      if (RESET) begin
         state         <= LOAD_IDLE;
         line_cnt      <= '0;
         mem_we        <= 1'b0;
         start_address <= RESET_START_ADDRESS;
      end else begin
         // Write strobe lasts one cycle
         mem_we <= 1'b0;

         if (rim_disable) begin
            state    <= LOAD_IDLE;
            line_cnt <= '0;
         end else if (rim_enable) begin
            // Fresh record alignment on entry
            state    <= LOAD_RIM;
            line_cnt <= '0;
         end else if (state == LOAD_RIM && byte_valid) begin
            if (line_cnt == LAST_LINE) begin
               line_cnt <= '0;
               case (rec_op)
                  RIM_DIO: mem_we <= 1'b1;
                  RIM_JMP: begin
                     start_address <= rec_next.addr;
                     state         <= LOAD_IDLE;
                  end
                  // Unknown opcodes fall through
                  default: ;
               endcase
            end else begin
               line_cnt <= line_cnt + 1'b1;
            end
         end
      end
   end

   // ================================================
   // Hold-off and its timeout
   // ================================================
   always_ff @(posedge CLK_50M) begin
      if (RESET) begin
         timer_q   <= '0;
         tape.hold <= 1'b0;
      end else begin
         // Restart on each counted line
         if (byte_valid) begin
            timer_q <= '0;
         end else if (timer_q != TIMER_SAT) begin
            timer_q <= timer_q + 1'b1;
         end

         // Release beats the jmp set
         if (!tape.download || rim_disable || timer_q > TIMER_LIMIT) begin
            tape.hold <= 1'b0;
         end else if (record_done && rec_op == RIM_JMP) begin
            tape.hold <= 1'b1;
         end
      end
   end

   // Write only comes out of an active read-in session
   a_we_in_rim: assert property (@(posedge CLK_50M) disable iff (RESET)
      mem_we |-> $past(state == LOAD_RIM) && state == LOAD_RIM);

   a_we_single: assert property (@(posedge CLK_50M) disable iff (RESET)
      mem_we |=> !mem_we);

endmodule

// ==== hw/tape_word_reader.sv ====
/*
 * Binary tape reader. A rising read_request arms it, then three binary
 * lines from the stream make one 18-bit word. busy falls with the word.
 */
`timescale 1ns/1ps

module tape_word_reader import pdp1_pkg::*; (
   input  logic      CLK_50M,
   input  logic      RESET,
   tape_if.reader    tape,
   input  logic      read_request,
   output logic      busy,
   output pdp_word_t word
);

   localparam int unsigned CNT_W = $clog2(BIN_LINES);
   localparam logic [CNT_W-1:0] LAST_FIELD = CNT_W'(BIN_LINES - 1);

   reader_state_e              state;
   logic                       req_q;
   logic [CNT_W-1:0]           field_cnt;
   logic [(BIN_LINES-1)*6-1:0] field_sr;   // Older fields, first one on top
   logic                       req_rise;
   logic                       byte_valid;

   assign req_rise   = read_request && !req_q;
   assign byte_valid = tape.byte_wr && tape.byte_data[7];
   assign busy       = (state == READ_COLLECT);

   // ================================================
   // Field collection
   // ================================================
   always_ff @(posedge CLK_50M) begin
      if (RESET) begin
         state     <= READ_IDLE;
         req_q     <= 1'b0;
         field_cnt <= '0;
      end else begin
         req_q <= read_request;
         case (state)
            READ_IDLE: begin
               if (req_rise) begin
                  state     <= READ_COLLECT;
                  field_cnt <= '0;
               end
            end
            READ_COLLECT: begin
               // Third field closes the word
               if (byte_valid) begin
                  if (field_cnt == LAST_FIELD) begin
                     state <= READ_IDLE;
                  end else begin
                     field_cnt <= field_cnt + 1'b1;
                  end
               end
            end
            default: state <= READ_IDLE;
         endcase
      end
   end

   // Word includes the line arriving on the closing edge
   always_ff @(posedge CLK_50M) begin
      if (busy && byte_valid) begin
         field_sr <= {field_sr[(BIN_LINES-2)*6-1:0], tape.byte_data[5:0]};
         if (field_cnt == LAST_FIELD) begin
            word <= {field_sr, tape.byte_data[5:0]};
         end
      end
   end

   a_busy_fall: assert property (@(posedge CLK_50M) disable iff (RESET)
      $fell(busy) |-> $past(tape.byte_wr && tape.byte_data[7]));

endmodule

// ==== hw/video_sync_gen.sv ====
/*
 * Line and frame counters with registered hsync, vsync and data enable.
 * Counts run from zero up to the TOTAL value inclusive.
 */
`timescale 1ns/1ps

module video_sync_gen import pdp1_pkg::*; #(
   parameter int unsigned H_TOTAL         = 1687,
   parameter int unsigned H_FRONT         = 48,
   parameter int unsigned H_SYNC          = 112,
   parameter int unsigned H_VISIBLE_START = 408,
   parameter int unsigned V_TOTAL         = 1065,
   parameter int unsigned V_FRONT         = 1,
   parameter int unsigned V_SYNC          = 3,
   parameter int unsigned V_VISIBLE_START = 42
) (
   input  logic CLK_50M,
   input  logic RESET,
   output logic hsync,
   output logic vsync,
   output logic de
);

   video_count_t h_count;
   video_count_t v_count;

   // ================================================
   // Position counters
   // ================================================
   always_ff @(posedge CLK_50M) begin
      if (RESET) begin
         h_count <= '0;
         v_count <= '0;
      end else if (h_count == video_count_t'(H_TOTAL)) begin
         // End of line, step the frame
         h_count <= '0;
         if (v_count == video_count_t'(V_TOTAL)) begin
            v_count <= '0;
         end else begin
            v_count <= v_count + 1'b1;
         end
      end else begin
         h_count <= h_count + 1'b1;
      end
   end

   // Outputs trail the counts by one cycle
   always_ff @(posedge CLK_50M) begin
      if (RESET) begin
         hsync <= 1'b1;
         vsync <= 1'b1;
         de    <= 1'b0;
      end else begin
         // Sync pulses are active low
         hsync <= !(h_count >= H_FRONT && h_count < H_FRONT + H_SYNC);
         vsync <= !(v_count >= V_FRONT && v_count < V_FRONT + V_SYNC);
         de    <= (h_count >= H_VISIBLE_START) && (v_count >= V_VISIBLE_START);
      end
   end

   // Sync sits in the blanking before visible start
   a_no_de_in_hsync: assert property (@(posedge CLK_50M) disable iff (RESET)
      !hsync |-> !de);

endmodule

// ==== hw/pdp1_frontend.sv ====
/*
 * PDP-1 front end top level. Joins the RIM loader, binary tape reader and
 * video sync generator on CLK_50M and sets their timing parameters.
 */
`timescale 1ns/1ps

module pdp1_frontend import pdp1_pkg::*; #(
   parameter int unsigned TIMEOUT_CYCLES  = 50_000_000,
   parameter int unsigned H_TOTAL         = 1687,
   parameter int unsigned H_FRONT         = 48,
   parameter int unsigned H_SYNC          = 112,
   parameter int unsigned H_VISIBLE_START = 408,
   parameter int unsigned V_TOTAL         = 1065,
   parameter int unsigned V_FRONT         = 1,
   parameter int unsigned V_SYNC          = 3,
   parameter int unsigned V_VISIBLE_START = 42
) (
   input  logic       CLK_50M,
   input  logic       RESET,
   input  logic       tape_download,
   input  logic       tape_wr,
   input  tape_byte_t tape_data,
   output logic       tape_hold,
   input  logic       rim_enable,
   input  logic       rim_disable,
   output logic       rim_active,
   output logic       mem_we,
   output pdp_addr_t  mem_addr,
   output pdp_word_t  mem_data,
   output pdp_addr_t  start_address,
   input  logic       read_request,
   output logic       reader_busy,
   output pdp_word_t  reader_word,
   output logic       hsync,
   output logic       vsync,
   output logic       de
);

   // Source side of the tape stream
   tape_if tape_bus ();

   assign tape_bus.download  = tape_download;
   assign tape_bus.byte_wr   = tape_wr;
   assign tape_bus.byte_data = tape_data;
   assign tape_hold          = tape_bus.hold;

   rim_loader #(
      .TIMEOUT_CYCLES (TIMEOUT_CYCLES)
   ) u_rim_loader (
      .CLK_50M       (CLK_50M),
      .RESET         (RESET),
      .tape          (tape_bus.loader),
      .rim_enable    (rim_enable),
      .rim_disable   (rim_disable),
      .rim_active    (rim_active),
      .mem_we        (mem_we),
      .mem_addr      (mem_addr),
      .mem_data      (mem_data),
      .start_address (start_address)
   );

   tape_word_reader u_tape_word_reader (
      .CLK_50M      (CLK_50M),
      .RESET        (RESET),
      .tape         (tape_bus.reader),
      .read_request (read_request),
      .busy         (reader_busy),
      .word         (reader_word)
   );

   video_sync_gen #(
      .H_TOTAL         (H_TOTAL),
      .H_FRONT         (H_FRONT),
      .H_SYNC          (H_SYNC),
      .H_VISIBLE_START (H_VISIBLE_START),
      .V_TOTAL         (V_TOTAL),
      .V_FRONT         (V_FRONT),
      .V_SYNC          (V_SYNC),
      .V_VISIBLE_START (V_VISIBLE_START)
   ) u_video_sync_gen (
      .CLK_50M (CLK_50M),
      .RESET   (RESET),
      .hsync   (hsync),
      .vsync   (vsync),
      .de      (de)
   );

endmodule

// ==== sim/tb_pdp1_frontend.sv ====
/*
 * Self-checking testbench for the PDP-1 front end. Drives the tape stream,
 * RIM controls and reader request, and checks writes, words and video timing.
 * Run through the Verilator Makefile in the project root.
 */
`timescale 1ns/1ps

module tb_pdp1_frontend import pdp1_pkg::*; ();

   // Small timing so a frame is short
   localparam int TIMEOUT_CYCLES  = 200;
   localparam int H_TOTAL         = 39;
   localparam int H_FRONT         = 2;
   localparam int H_SYNC          = 4;
   localparam int H_VISIBLE_START = 8;
   localparam int V_TOTAL         = 9;
   localparam int V_FRONT         = 1;
   localparam int V_SYNC          = 2;
   localparam int V_VISIBLE_START = 3;

   localparam int N_DIO           = 8;
   localparam int N_READS         = 4;
   // dio records plus two jmp records and one aborted record, fillers included
   localparam int TOTAL_BYTES     = (N_DIO + 3) * RIM_LINES * 2 + N_READS * BIN_LINES * 3;
   localparam int FRAME_CYCLES    = (H_TOTAL + 1) * (V_TOTAL + 1);
   localparam int WATCHDOG_CYCLES = TOTAL_BYTES * 3 + 2 * FRAME_CYCLES + TIMEOUT_CYCLES + 500;

   logic       CLK_50M = 1'b0;
   logic       RESET;
   logic       tape_download;
   logic       tape_wr;
   tape_byte_t tape_data;
   logic       tape_hold;
   logic       rim_enable;
   logic       rim_disable;
   logic       rim_active;
   logic       mem_we;
   pdp_addr_t  mem_addr;
   pdp_word_t  mem_data;
   pdp_addr_t  start_address;
   logic       read_request;
   logic       reader_busy;
   pdp_word_t  reader_word;
   logic       hsync;
   logic       vsync;
   logic       de;

   // Expected results, filled by the stimulus, drained by the checker
   pdp_addr_t   exp_addr_q[$];
   pdp_word_t   exp_data_q[$];
   pdp_word_t   exp_word_q[$];
   rim_record_t rec_list[$];
   pdp_addr_t   exp_start;

   // Video model state
   video_count_t model_h;
   video_count_t model_v;
   logic [2:0]   exp_video;
   logic         video_valid;
   int           frames_seen;
   logic         busy_q;

   always #10 CLK_50M = ~CLK_50M;

   pdp1_frontend #(
      .TIMEOUT_CYCLES  (TIMEOUT_CYCLES),
      .H_TOTAL         (H_TOTAL),
      .H_FRONT         (H_FRONT),
      .H_SYNC          (H_SYNC),
      .H_VISIBLE_START (H_VISIBLE_START),
      .V_TOTAL         (V_TOTAL),
      .V_FRONT         (V_FRONT),
      .V_SYNC          (V_SYNC),
      .V_VISIBLE_START (V_VISIBLE_START)
   ) DUT (
      .CLK_50M       (CLK_50M),
      .RESET         (RESET),
      .tape_download (tape_download),
      .tape_wr       (tape_wr),
      .tape_data     (tape_data),
      .tape_hold     (tape_hold),
      .rim_enable    (rim_enable),
      .rim_disable   (rim_disable),
      .rim_active    (rim_active),
      .mem_we        (mem_we),
      .mem_addr      (mem_addr),
      .mem_data      (mem_data),
      .start_address (start_address),
      .read_request  (read_request),
      .reader_busy   (reader_busy),
      .reader_word   (reader_word),
      .hsync         (hsync),
      .vsync         (vsync),
      .de            (de)
   );

   // ==================================================
   // Reporting and compare tasks
   // ==================================================
   task automatic stop_with_failure(input string why);
      $display("%s", why);
      $display("RESULT: FAIL");
      $fatal(1, "simulation stopped on first error");
   endtask

   task automatic check_addr(input string name, input pdp_addr_t got, input pdp_addr_t exp);
      if (got !== exp) begin
         stop_with_failure($sformatf("** Error at %0t: %s is %o, expected %o",
                                     $time, name, got, exp));
      end
   endtask

   task automatic check_word(input string name, input pdp_word_t got, input pdp_word_t exp);
      if (got !== exp) begin
         stop_with_failure($sformatf("** Error at %0t: %s is %o, expected %o",
                                     $time, name, got, exp));
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         stop_with_failure($sformatf("** Error at %0t: %s is %b, expected %b",
                                     $time, name, got, exp));
      end
   endtask

   // ==================================================
   // Reference models
   // ==================================================
   // Writes in list order until the first jmp ends read-in
   function automatic void expect_records();
      logic jumped;
      jumped = 1'b0;
      foreach (rec_list[i]) begin
         if (!jumped && rec_list[i].op == RIM_DIO) begin
            exp_addr_q.push_back(rec_list[i].addr);
            exp_data_q.push_back(rec_list[i].data);
         end else if (!jumped && rec_list[i].op == RIM_JMP) begin
            exp_start = rec_list[i].addr;
            jumped    = 1'b1;
         end
      end
   endfunction

   // Oldest field lands in the high bits
   function automatic pdp_word_t expect_word(input tape_byte_t b0, input tape_byte_t b1,
                                             input tape_byte_t b2);
      return {b0[5:0], b1[5:0], b2[5:0]};
   endfunction

   // {hsync, vsync, de} for one counter position, syncs active low
   function automatic logic [2:0] expect_video(input video_count_t h, input video_count_t v);
      logic hs;
      logic vs;
      logic en;
      hs = !(int'(h) >= H_FRONT && int'(h) < H_FRONT + H_SYNC);
      vs = !(int'(v) >= V_FRONT && int'(v) < V_FRONT + V_SYNC);
      en = (int'(h) >= H_VISIBLE_START) && (int'(v) >= V_VISIBLE_START);
      return {hs, vs, en};
   endfunction

   // ==================================================
   // Byte helpers
   // ==================================================
   function automatic tape_byte_t binary_byte(input logic [5:0] field);
      return {1'b1, 1'($urandom), field};
   endfunction

   function automatic tape_byte_t filler_byte();
      return {1'b0, 7'($urandom)};
   endfunction

   function automatic logic [5:0] rec_field(input rim_record_t r, input int idx);
      logic [35:0] bits;
      bits = r;
      return bits[35 - 6 * idx -: 6];
   endfunction

   // Strobe, then two idle cycles; waits out the hold-off first
   task automatic send_byte(input tape_byte_t b);
      @(posedge CLK_50M);
      while (tape_hold) begin
         @(posedge CLK_50M);
      end
      tape_wr   <= 1'b1;
      tape_data <= b;
      @(posedge CLK_50M);
      tape_wr <= 1'b0;
      @(posedge CLK_50M);
   endtask

   task automatic maybe_filler();
      if ($urandom % 2 == 1) begin
         send_byte(filler_byte());
      end
   endtask

   task automatic send_record(input rim_record_t r, input logic with_filler);
      for (int i = 0; i < RIM_LINES; i++) begin
         send_byte(binary_byte(rec_field(r, i)));
         if (with_filler) begin
            maybe_filler();
         end
      end
   endtask

   // ==================================================
   // Video model, one step per clock
   // ==================================================
   always @(posedge CLK_50M) begin
      if (RESET) begin
         model_h     = '0;
         model_v     = '0;
         video_valid = 1'b0;
      end else begin
         exp_video   = expect_video(model_h, model_v);
         video_valid = 1'b1;
         if (model_h == video_count_t'(H_TOTAL)) begin
            model_h = '0;
            if (model_v == video_count_t'(V_TOTAL)) begin
               model_v     = '0;
               frames_seen = frames_seen + 1;
            end else begin
               model_v = model_v + 1'b1;
            end
         end else begin
            model_h = model_h + 1'b1;
         end
      end
   end

   // ==================================================
   // Checker, samples on the falling edge
   // ==================================================
   always @(negedge CLK_50M) begin
      if (RESET) begin
         busy_q = 1'b0;
      end else begin
         if (mem_we && exp_addr_q.size() == 0) begin
            stop_with_failure("Memory write seen while no write was expected");
         end else if (mem_we) begin
            check_addr("mem_addr", mem_addr, exp_addr_q.pop_front());
            check_word("mem_data", mem_data, exp_data_q.pop_front());
         end
         // Fall of busy ends a read
         if (busy_q && !reader_busy && exp_word_q.size() == 0) begin
            stop_with_failure("Reader finished a word that was never requested");
         end else if (busy_q && !reader_busy) begin
            check_word("reader_word", reader_word, exp_word_q.pop_front());
         end
         busy_q = reader_busy;
         if (video_valid) begin
            check_bit("hsync", hsync, exp_video[2]);
            check_bit("vsync", vsync, exp_video[1]);
            check_bit("de", de, exp_video[0]);
         end
      end
   end

   // Watchdog
   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge CLK_50M);
      stop_with_failure("Watchdog expired before the tests completed");
   end

   // ==================================================
   // Stimulus
   // ==================================================
   initial begin
      rim_record_t rec;
      tape_byte_t  b0;
      tape_byte_t  b1;
      tape_byte_t  b2;
      int          i;
      int          n;

      void'($urandom(32'h67e4_693f));
      frames_seen   = 0;
      RESET         <= 1'b1;
      tape_download <= 1'b0;
      tape_wr       <= 1'b0;
      tape_data     <= '0;
      rim_enable    <= 1'b0;
      rim_disable   <= 1'b0;
      read_request  <= 1'b0;
      repeat (4) @(posedge CLK_50M);
      RESET <= 1'b0;

      // Values straight out of reset
      @(negedge CLK_50M);
      check_bit("rim_active", rim_active, 1'b0);
      check_bit("mem_we", mem_we, 1'b0);
      check_bit("reader_busy", reader_busy, 1'b0);
      check_bit("tape_hold", tape_hold, 1'b0);
      check_addr("start_address", start_address, 12'o4);

      // Random dio records with fillers between lines
      @(posedge CLK_50M);
      tape_download <= 1'b1;
      rim_enable    <= 1'b1;
      @(posedge CLK_50M);
      rim_enable <= 1'b0;
      @(negedge CLK_50M);
      check_bit("rim_active", rim_active, 1'b1);
      rec_list.delete();
      for (i = 0; i < N_DIO; i++) begin
         rec.op   = RIM_DIO;
         rec.addr = pdp_addr_t'($urandom);
         rec.data = pdp_word_t'($urandom);
         rec_list.push_back(rec);
      end
      expect_records();
      foreach (rec_list[k]) begin
         send_record(rec_list[k], 1'b1);
      end
      if (exp_addr_q.size() != 0) begin
         stop_with_failure("Some dio records produced no memory write");
      end

      // jmp record, hold released by download going low
      rec_list.delete();
      rec.op   = RIM_JMP;
      rec.addr = pdp_addr_t'($urandom);
      rec.data = pdp_word_t'($urandom);
      rec_list.push_back(rec);
      expect_records();
      send_record(rec, 1'b0);
      @(negedge CLK_50M);
      check_addr("start_address", start_address, exp_start);
      check_bit("rim_active", rim_active, 1'b0);
      check_bit("tape_hold", tape_hold, 1'b1);
      @(posedge CLK_50M);
      tape_download <= 1'b0;
      @(posedge CLK_50M);
      @(negedge CLK_50M);
      check_bit("tape_hold", tape_hold, 1'b0);

      // Second jmp, hold released by the timeout
      @(posedge CLK_50M);
      tape_download <= 1'b1;
      rim_enable    <= 1'b1;
      @(posedge CLK_50M);
      rim_enable <= 1'b0;
      rec_list.delete();
      rec.addr = pdp_addr_t'($urandom);
      rec_list.push_back(rec);
      expect_records();
      send_record(rec, 1'b0);
      @(negedge CLK_50M);
      check_addr("start_address", start_address, exp_start);
      check_bit("tape_hold", tape_hold, 1'b1);
      repeat (TIMEOUT_CYCLES - 4) @(posedge CLK_50M);
      @(negedge CLK_50M);
      check_bit("tape_hold", tape_hold, 1'b1);
      n = 0;
      while (tape_hold === 1'b1 && n < 10) begin
         @(negedge CLK_50M);
         n = n + 1;
      end
      check_bit("tape_hold", tape_hold, 1'b0);

      // rim_disable halfway through a record
      @(posedge CLK_50M);
      rim_enable <= 1'b1;
      @(posedge CLK_50M);
      rim_enable <= 1'b0;
      rec.op   = RIM_DIO;
      rec.addr = pdp_addr_t'($urandom);
      rec.data = pdp_word_t'($urandom);
      for (i = 0; i < 3; i++) begin
         send_byte(binary_byte(rec_field(rec, i)));
      end
      @(posedge CLK_50M);
      rim_disable <= 1'b1;
      @(posedge CLK_50M);
      rim_disable <= 1'b0;
      @(negedge CLK_50M);
      check_bit("rim_active", rim_active, 1'b0);
      for (i = 3; i < RIM_LINES; i++) begin
         send_byte(binary_byte(rec_field(rec, i)));
      end

      // Binary reader words with ignored filler lines
      for (i = 0; i < N_READS; i++) begin
         b0 = binary_byte(6'($urandom));
         b1 = binary_byte(6'($urandom));
         b2 = binary_byte(6'($urandom));
         exp_word_q.push_back(expect_word(b0, b1, b2));
         @(posedge CLK_50M);
         read_request <= 1'b1;
         @(posedge CLK_50M);
         read_request <= 1'b0;
         @(negedge CLK_50M);
         check_bit("reader_busy", reader_busy, 1'b1);
         maybe_filler();
         send_byte(b0);
         maybe_filler();
         send_byte(b1);
         maybe_filler();
         send_byte(b2);
         n = 0;
         while (reader_busy === 1'b1 && n < 8) begin
            @(negedge CLK_50M);
            n = n + 1;
         end
         if (exp_word_q.size() != 0) begin
            stop_with_failure("Reader did not finish the requested word");
         end
      end

      // Video checked throughout, at least two whole frames
      while (frames_seen < 2) begin
         @(posedge CLK_50M);
      end
      @(negedge CLK_50M);

      if (exp_addr_q.size() != 0 || exp_word_q.size() != 0) begin
         stop_with_failure("Expected results were still pending at the end of the run");
      end else begin
         $display("RESULT: PASS");
         $finish;
      end
   end

endmodule

// ==== all.f ====
hw/pdp1_pkg.sv
hw/tape_if.sv
hw/rim_loader.sv
hw/tape_word_reader.sv
hw/video_sync_gen.sv
hw/pdp1_frontend.sv
sim/tb_pdp1_frontend.sv

// ==== Makefile ====
# Verilator build and run for the PDP-1 front end testbench

VERILATOR ?= verilator
TOP       ?= tb_pdp1_frontend
OBJ_DIR   ?= obj_dir
FILELIST  ?= all.f
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# Rebuild only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# Exit status of the binary is the test result
run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)
